/* include/epu_cfg.svh */
// EPU configuration
`ifndef EPU_CFG_SVH
`define EPU_CFG_SVH

// Datapath
`define EPU_DW            32
`define EPU_INSN_SHIFT    2
`define EPU_PC_W          (`EPU_DW - `EPU_INSN_SHIFT)
`define EPU_IMM_W         15

// Exception vectors
// Low EVECT bits replaced by the vector offset
`define EPU_VECT_W        12
`define EPU_VECT_SYSCALL  12'h100
`define EPU_VECT_EINSN    12'h200

// Identification registers
`define EPU_CPUID         32'h4e43_5055
`define EPU_COREID        32'h0000_0000

`endif

/* verilog/epu_msr_pkg.sv */
// MSR address map and field layout

package epu_msr_pkg;

   // Address split: bank in bits 12..9, offset in bits 8..0
   localparam int MSR_OFF_W  = 9;
   localparam int MSR_BANK_W = 4;

   typedef enum logic [MSR_BANK_W-1:0] {
      MSR_BANK_PS  = 4'd0,
      MSR_BANK_TSC = 4'd7
   } msr_bank_e;

   // One-hot offsets inside the PS bank
   typedef enum logic [MSR_OFF_W-1:0] {
      MSR_PSR    = 9'h001,
      MSR_CPUID  = 9'h002,
      MSR_EPSR   = 9'h004,
      MSR_EPC    = 9'h008,
      MSR_ELSA   = 9'h010,
      MSR_COREID = 9'h020,
      MSR_EVECT  = 9'h040
   } msr_ps_off_e;

   typedef enum logic [MSR_OFF_W-1:0] {
      MSR_TSR = 9'h001,
      MSR_TCR = 9'h002
   } msr_tsc_off_e;

   // Bit 0 is RM, bit 5 is DCE
   typedef struct packed {
      logic dce;
      logic ice;
      logic dmme;
      logic imme;
      logic ire;
      logic rm;
   } psr_t;

   localparam psr_t PSR_RESET = 6'b000001;

   // WMSR takes the PSR fields from write data bits 9..4
   localparam int PSR_WR_LSB = 4;

   typedef struct packed {
      logic psr;
      logic epsr;
      logic epc;
      logic elsa;
      logic evect;
      logic tsr;
      logic tcr;
   } msr_wsel_t;

   // TCR fields
   localparam int TCR_CNT_W  = 28;
   localparam int TCR_EN_BIT = 28;
   localparam int TCR_I_BIT  = 29;

endpackage

/* verilog/epu_pipe_pkg.sv */
// EPU operations and exception requests

package epu_pipe_pkg;

   typedef enum logic [2:0] {
      EPU_OP_NONE    = 3'd0,
      EPU_OP_RMSR    = 3'd1,
      EPU_OP_WMSR    = 3'd2,
      EPU_OP_SYSCALL = 3'd3,
      EPU_OP_EINSN   = 3'd4,
      EPU_OP_ERET    = 3'd5
   } epu_op_e;

   // At most one of these travels with an item
   typedef struct packed {
      logic syscall;
      logic einsn;
      logic eret;
   } exc_req_t;

endpackage

/* verilog/epu_decode.sv */
// EPU stage one decode
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_decode
   import epu_msr_pkg::*, epu_pipe_pkg::*;
(
   input  logic                  ex_valid,
   input  epu_op_e               ex_op,
   input  logic [`EPU_DW-1:0]    ex_operand1,
   input  logic [`EPU_DW-1:0]    ex_operand2,
   input  logic [`EPU_IMM_W-1:0] ex_imm,
   input  logic                  exc_flush,
   input  psr_t                  msr_psr,
   input  psr_t                  msr_epsr,
   input  logic [`EPU_DW-1:0]    msr_epc,
   input  logic [`EPU_DW-1:0]    msr_elsa,
   input  logic [`EPU_DW-1:0]    msr_evect,
   input  logic [`EPU_DW-1:0]    tsr,
   input  logic [`EPU_DW-1:0]    tcr,
   output logic [`EPU_DW-1:0]    epu_dout,
   output logic                  epu_dout_valid,
   output msr_wsel_t             s1_wsel,
   output exc_req_t              s1_exc,
   output logic                  s1_flush_psr,
   output logic [`EPU_DW-1:0]    s1_wdat
);

   logic [`EPU_DW-1:0]     msr_addr;
   logic [MSR_BANK_W-1:0]  bank;
   logic [MSR_OFF_W-1:0]   off;
   logic                   bank_ps;
   logic                   bank_tsc;
   logic                   live;
   logic                   wmsr;
   logic [`EPU_DW-1:0]     dout_ps;
   logic [`EPU_DW-1:0]     dout_tsc;

   assign msr_addr = ex_operand1 | {{(`EPU_DW-`EPU_IMM_W){1'b0}}, ex_imm};
   assign bank     = msr_addr[MSR_OFF_W +: MSR_BANK_W];
   assign off      = msr_addr[MSR_OFF_W-1:0];
   assign bank_ps  = (bank == MSR_BANK_PS);
   assign bank_tsc = (bank == MSR_BANK_TSC);

   // Item is dropped when invalid or when stage two flushes
   assign live = ex_valid & ~exc_flush;
   assign wmsr = live & (ex_op == EPU_OP_WMSR);

   //////////////////////////////////////////////////
   // Read multiplexer
   //////////////////////////////////////////////////
   assign dout_ps =
      ({`EPU_DW{|(off & MSR_PSR)}}    & {{(`EPU_DW-$bits(psr_t)){1'b0}}, msr_psr}) |
      ({`EPU_DW{|(off & MSR_CPUID)}}  & `EPU_CPUID) |
      ({`EPU_DW{|(off & MSR_EPSR)}}   & {{(`EPU_DW-$bits(psr_t)){1'b0}}, msr_epsr}) |
      ({`EPU_DW{|(off & MSR_EPC)}}    & msr_epc) |
      ({`EPU_DW{|(off & MSR_ELSA)}}   & msr_elsa) |
      ({`EPU_DW{|(off & MSR_COREID)}} & `EPU_COREID) |
      ({`EPU_DW{|(off & MSR_EVECT)}}  & msr_evect);

   assign dout_tsc =
      ({`EPU_DW{|(off & MSR_TSR)}} & tsr) |
      ({`EPU_DW{|(off & MSR_TCR)}} & tcr);

   // Unmapped banks read as zero
   assign epu_dout = ({`EPU_DW{bank_ps}} & dout_ps) | ({`EPU_DW{bank_tsc}} & dout_tsc);
   assign epu_dout_valid = live & (ex_op == EPU_OP_RMSR);

   //////////////////////////////////////////////////
   // Commit record
   //////////////////////////////////////////////////
   assign s1_wsel.psr   = wmsr & bank_ps & |(off & MSR_PSR);
   assign s1_wsel.epsr  = wmsr & bank_ps & |(off & MSR_EPSR);
   assign s1_wsel.epc   = wmsr & bank_ps & |(off & MSR_EPC);
   assign s1_wsel.elsa  = wmsr & bank_ps & |(off & MSR_ELSA);
   assign s1_wsel.evect = wmsr & bank_ps & |(off & MSR_EVECT);
   assign s1_wsel.tsr   = wmsr & bank_tsc & |(off & MSR_TSR);
   assign s1_wsel.tcr   = wmsr & bank_tsc & |(off & MSR_TCR);

   assign s1_exc.syscall = live & (ex_op == EPU_OP_SYSCALL);
   assign s1_exc.einsn   = live & (ex_op == EPU_OP_EINSN);
   assign s1_exc.eret    = live & (ex_op == EPU_OP_ERET);

   // PSR change refetches from npc
   assign s1_flush_psr = s1_wsel.psr;
   assign s1_wdat      = ex_operand2;

endmodule

/* verilog/epu_commit.sv */
// EPU stage two commit
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_commit
   import epu_msr_pkg::*, epu_pipe_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  p_ce,
   input  msr_wsel_t             s1_wsel,
   input  exc_req_t              s1_exc,
   input  logic                  s1_flush_psr,
   input  logic [`EPU_DW-1:0]    s1_wdat,
   input  logic [`EPU_PC_W-1:0]  ex_pc,
   input  logic [`EPU_PC_W-1:0]  ex_npc,
   input  logic [`EPU_DW-1:0]    msr_epc,
   input  logic [`EPU_DW-1:0]    msr_evect,
   output msr_wsel_t             commit_wsel,
   output logic [`EPU_DW-1:0]    commit_wdat,
   output logic                  psr_save,
   output logic                  psr_restore,
   output logic [`EPU_DW-1:0]    exc_epc,
   output logic [`EPU_DW-1:0]    exc_elsa,
   output logic                  exc_flush,
   output logic [`EPU_PC_W-1:0]  exc_flush_tgt
);

   localparam logic [`EPU_VECT_W-1:0] VECT_SYSCALL = `EPU_VECT_SYSCALL;
   localparam logic [`EPU_VECT_W-1:0] VECT_EINSN   = `EPU_VECT_EINSN;

   msr_wsel_t                        s2_wsel;
   exc_req_t                         s2_exc;
   logic                             s2_flush_psr;
   logic [`EPU_DW-1:0]               s2_wdat;
   logic [`EPU_PC_W-1:0]             s2_pc;
   logic [`EPU_PC_W-1:0]             s2_npc;
   msr_wsel_t                        s2_wsel_exc;
   logic [`EPU_DW-`EPU_VECT_W-1:0]   vect_hi;

   // Stage-two record, a bubble after reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s2_wsel      <= '0;
         s2_exc       <= '0;
         s2_flush_psr <= 1'b0;
      end
      else if (p_ce)
      begin
         s2_wsel      <= s1_wsel;
         s2_exc       <= s1_exc;
         s2_flush_psr <= s1_flush_psr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         s2_wdat <= s1_wdat;
         s2_pc   <= ex_pc;
         s2_npc  <= ex_npc;
      end
   end

   // Illegal instruction also records its PC in ELSA
   always_comb
   begin
      s2_wsel_exc      = s2_wsel;
      s2_wsel_exc.elsa = s2_wsel.elsa | s2_exc.einsn;
   end

   assign commit_wsel = p_ce ? s2_wsel_exc : '0;
   assign commit_wdat = s2_wdat;

   assign psr_save    = p_ce & (s2_exc.syscall | s2_exc.einsn);
   assign psr_restore = p_ce & s2_exc.eret;

   // Syscall resumes after itself, EINSN retries
   assign exc_epc  = {(s2_exc.syscall ? s2_npc : s2_pc), {`EPU_INSN_SHIFT{1'b0}}};
   assign exc_elsa = {s2_pc, {`EPU_INSN_SHIFT{1'b0}}};

   //////////////////////////////////////////////////
   // Flush and target
   //////////////////////////////////////////////////
   assign exc_flush = p_ce & (s2_exc.syscall | s2_exc.einsn | s2_exc.eret | s2_flush_psr);

   assign vect_hi = msr_evect[`EPU_DW-1:`EPU_VECT_W];

   assign exc_flush_tgt =
      ({`EPU_PC_W{s2_exc.syscall}} &
         {vect_hi, VECT_SYSCALL[`EPU_VECT_W-1:`EPU_INSN_SHIFT]}) |
      ({`EPU_PC_W{s2_exc.einsn}} &
         {vect_hi, VECT_EINSN[`EPU_VECT_W-1:`EPU_INSN_SHIFT]}) |
      ({`EPU_PC_W{s2_exc.eret}} & msr_epc[`EPU_INSN_SHIFT +: `EPU_PC_W]) |
      ({`EPU_PC_W{s2_flush_psr}} & s2_npc);

endmodule

/* verilog/epu_msr_file.sv */
// Processor-state MSR bank
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_msr_file
   import epu_msr_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  msr_wsel_t           commit_wsel,
   input  logic [`EPU_DW-1:0]  commit_wdat,
   input  logic                psr_save,
   input  logic                psr_restore,
   input  logic [`EPU_DW-1:0]  exc_epc,
   input  logic [`EPU_DW-1:0]  exc_elsa,
   output psr_t                msr_psr,
   output psr_t                msr_epsr,
   output logic [`EPU_DW-1:0]  msr_epc,
   output logic [`EPU_DW-1:0]  msr_elsa,
   output logic [`EPU_DW-1:0]  msr_evect
);

   psr_t psr_exc;

   // Entering an exception: kernel mode, interrupts off
   always_comb
   begin
      psr_exc     = msr_psr;
      psr_exc.rm  = 1'b1;
      psr_exc.ire = 1'b0;
   end

   //////////////////////////////////////////////////
   // PSR and EPSR
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         msr_psr  <= PSR_RESET;
         msr_epsr <= '0;
      end
      else
      begin
         if (psr_save)
            msr_psr <= psr_exc;
         else if (psr_restore)
            msr_psr <= msr_epsr;
         else if (commit_wsel.psr)
            msr_psr <= psr_t'(commit_wdat[PSR_WR_LSB +: $bits(psr_t)]);

         if (psr_save)
            msr_epsr <= msr_psr;
         else if (commit_wsel.epsr)
            msr_epsr <= psr_t'(commit_wdat[$bits(psr_t)-1:0]);
      end
   end

   //////////////////////////////////////////////////
   // Exception address registers
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         msr_epc   <= '0;
         msr_elsa  <= '0;
         msr_evect <= '0;
      end
      else
      begin
         if (psr_save)
            msr_epc <= exc_epc;
         else if (commit_wsel.epc)
            msr_epc <= commit_wdat;

         // ELSA select comes with an EINSN save as well as with WMSR
         if (commit_wsel.elsa)
            msr_elsa <= psr_save ? exc_elsa : commit_wdat;

         if (commit_wsel.evect)
            msr_evect <= commit_wdat;
      end
   end

endmodule

/* verilog/epu_tsc.sv */
// Timestamp counter
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_tsc
   import epu_msr_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  msr_wsel_t           commit_wsel,
   input  logic [`EPU_DW-1:0]  commit_wdat,
   output logic [`EPU_DW-1:0]  tsr,
   output logic [`EPU_DW-1:0]  tcr,
   output logic                tsc_irq
);

   logic tcr_en;
   logic tcr_i;
   logic match;

   assign tcr_en = tcr[TCR_EN_BIT];
   assign tcr_i  = tcr[TCR_I_BIT];
   assign match  = (tsr == {{(`EPU_DW-TCR_CNT_W){1'b0}}, tcr[TCR_CNT_W-1:0]});

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tsr     <= '0;
         tcr     <= '0;
         tsc_irq <= 1'b0;
      end
      else
      begin
         if (commit_wsel.tsr)
            tsr <= commit_wdat;
         else if (tcr_en)
            tsr <= tsr + 1'b1;

         if (commit_wsel.tcr)
            tcr <= commit_wdat;

         // Sticky until software rewrites TCR
         if (commit_wsel.tcr)
            tsc_irq <= 1'b0;
         else if (tcr_en & tcr_i & match)
            tsc_irq <= 1'b1;
      end
   end

endmodule

/* verilog/epu_top.sv */
// Exception processing unit top
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_top
   import epu_msr_pkg::*, epu_pipe_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  p_ce,
   input  logic                  ex_valid,
   input  epu_op_e               ex_op,
   input  logic [`EPU_DW-1:0]    ex_operand1,
   input  logic [`EPU_DW-1:0]    ex_operand2,
   input  logic [`EPU_IMM_W-1:0] ex_imm,
   input  logic [`EPU_PC_W-1:0]  ex_pc,
   input  logic [`EPU_PC_W-1:0]  ex_npc,
   output logic [`EPU_DW-1:0]    epu_dout,
   output logic                  epu_dout_valid,
   output logic                  exc_flush,
   output logic [`EPU_PC_W-1:0]  exc_flush_tgt,
   output logic                  tsc_irq
);

   msr_wsel_t           s1_wsel;
   exc_req_t            s1_exc;
   logic                s1_flush_psr;
   logic [`EPU_DW-1:0]  s1_wdat;
   msr_wsel_t           commit_wsel;
   logic [`EPU_DW-1:0]  commit_wdat;
   logic                psr_save;
   logic                psr_restore;
   logic [`EPU_DW-1:0]  exc_epc;
   logic [`EPU_DW-1:0]  exc_elsa;
   psr_t                msr_psr;
   psr_t                msr_epsr;
   logic [`EPU_DW-1:0]  msr_epc;
   logic [`EPU_DW-1:0]  msr_elsa;
   logic [`EPU_DW-1:0]  msr_evect;
   logic [`EPU_DW-1:0]  tsr;
   logic [`EPU_DW-1:0]  tcr;

   epu_decode u_decode (
      .ex_valid, .ex_op, .ex_operand1, .ex_operand2, .ex_imm,
      .exc_flush,
      .msr_psr, .msr_epsr, .msr_epc, .msr_elsa, .msr_evect,
      .tsr, .tcr,
      .epu_dout, .epu_dout_valid,
      .s1_wsel, .s1_exc, .s1_flush_psr, .s1_wdat
   );

   epu_commit u_commit (
      .clk, .reset, .p_ce,
      .s1_wsel, .s1_exc, .s1_flush_psr, .s1_wdat,
      .ex_pc, .ex_npc, .msr_epc, .msr_evect,
      .commit_wsel, .commit_wdat, .psr_save, .psr_restore,
      .exc_epc, .exc_elsa, .exc_flush, .exc_flush_tgt
   );

   epu_msr_file u_msr_file (
      .clk, .reset, .commit_wsel, .commit_wdat,
      .psr_save, .psr_restore, .exc_epc, .exc_elsa,
      .msr_psr, .msr_epsr, .msr_epc, .msr_elsa, .msr_evect
   );

   epu_tsc u_tsc (
      .clk, .reset, .commit_wsel, .commit_wdat,
      .tsr, .tcr, .tsc_irq
   );

endmodule

/* sim/epu_props.sv */
// Commit stage properties
`timescale 1ns/1ps

module epu_props
   import epu_msr_pkg::*, epu_pipe_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      p_ce,
   input msr_wsel_t s1_wsel,
   input exc_req_t  s1_exc,
   input logic      s1_flush_psr,
   input exc_req_t  s2_exc,
   input logic      exc_flush
);

   logic seen_record;

   // Set once a real record has entered stage two
   always_ff @(posedge clk)
   begin
      if (reset)
         seen_record <= 1'b0;
      else if (p_ce & ((|s1_wsel) | (|s1_exc) | s1_flush_psr))
         seen_record <= 1'b1;
   end

   a_one_exc: assert property (@(posedge clk) disable iff (reset) $onehot0(s2_exc))
      else $error("More than one exception request in stage two");

   a_flush_ce: assert property (@(posedge clk) disable iff (reset) exc_flush |-> p_ce)
      else $error("exc_flush raised while p_ce is low");

   a_quiet_start: assert property (@(posedge clk) disable iff (reset)
      !seen_record |-> !exc_flush)
      else $error("exc_flush raised before any record reached stage two");

endmodule

bind epu_commit epu_props u_props (
   .clk, .reset, .p_ce, .s1_wsel, .s1_exc, .s1_flush_psr, .s2_exc, .exc_flush
);

/* sim/epu_tb.sv */
// EPU testbench
`timescale 1ns/1ps
`include "epu_cfg.svh"

module epu_tb
   import epu_pipe_pkg::*;
();

   localparam int VEC_WORDS    = 8;
   localparam int MAX_VECS     = 64;
   localparam int RESET_CYCLES = 10;
   localparam int IRQ_TIMEOUT  = 200;
   localparam logic [31:0] END_MARK = 32'h0000_00ff;

   // Flags in the chk column
   localparam logic [31:0] CHK_READ  = 32'h01;
   localparam logic [31:0] CHK_FLUSH = 32'h02;
   localparam logic [31:0] CHK_MIN   = 32'h04;
   localparam logic [31:0] WAIT_IRQ  = 32'h08;
   localparam logic [31:0] IRQ_LOW   = 32'h10;

   logic                  clk;
   logic                  reset;
   logic                  p_ce;
   logic                  ex_valid;
   epu_op_e               ex_op;
   logic [`EPU_DW-1:0]    ex_operand1;
   logic [`EPU_DW-1:0]    ex_operand2;
   logic [`EPU_IMM_W-1:0] ex_imm;
   logic [`EPU_PC_W-1:0]  ex_pc;
   logic [`EPU_PC_W-1:0]  ex_npc;
   logic [`EPU_DW-1:0]    epu_dout;
   logic                  epu_dout_valid;
   logic                  exc_flush;
   logic [`EPU_PC_W-1:0]  exc_flush_tgt;
   logic                  tsc_irq;

   // Eight words per vector: op opnd1 imm opnd2 pc npc chk exp
   logic [31:0] pat [0:VEC_WORDS*MAX_VECS-1];
   int          n_vecs;
   int          pass_cnt;
   int          fail_cnt;
   int          vec_errs;
   bit          timed_out;

   epu_top DUT (
      .clk, .reset, .p_ce, .ex_valid, .ex_op, .ex_operand1, .ex_operand2,
      .ex_imm, .ex_pc, .ex_npc, .epu_dout, .epu_dout_valid,
      .exc_flush, .exc_flush_tgt, .tsc_irq
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////
   // Both stages hold while p_ce is low
   task automatic stall_random();
      int n;
      n = $urandom_range(2, 0);
      repeat (n)
      begin
         @(posedge clk);
         p_ce <= 1'b0;
      end
   endtask

   task automatic wait_irq();
      int cycles;
      cycles = 0;
      while (!tsc_irq && cycles < IRQ_TIMEOUT)
      begin
         @(posedge clk);
         p_ce <= 1'b0;
         @(negedge clk);
         cycles++;
      end
      if (!tsc_irq)
      begin
         $display("Timeout: tsc_irq did not rise within %0d cycles", IRQ_TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   // One enabled cycle, sampled at the falling edge
   task automatic drive_vector(input int base, input bit valid);
      @(posedge clk);
      p_ce        <= 1'b1;
      ex_valid    <= valid;
      ex_op       <= epu_op_e'(pat[base][2:0]);
      ex_operand1 <= pat[base+1];
      ex_imm      <= pat[base+2][`EPU_IMM_W-1:0];
      ex_operand2 <= pat[base+3];
      ex_pc       <= pat[base+4][`EPU_PC_W-1:0];
      ex_npc      <= pat[base+5][`EPU_PC_W-1:0];
      @(negedge clk);
   endtask

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////
   task automatic verify_read(input int base);
      logic [31:0] chk;
      logic [31:0] exp;
      chk = pat[base+6];
      exp = pat[base+7];
      if ((chk & CHK_READ) != 0)
      begin
         assert (epu_dout_valid && epu_dout == exp)
         else
         begin
            $display("Fail at %0t: vector %0d read %h valid %0b, expected %h",
                     $time, base / VEC_WORDS, epu_dout, epu_dout_valid, exp);
            vec_errs++;
         end
      end
      if ((chk & CHK_MIN) != 0)
      begin
         assert (epu_dout_valid && epu_dout >= exp)
         else
         begin
            $display("Fail at %0t: vector %0d read %h, expected at least %h",
                     $time, base / VEC_WORDS, epu_dout, exp);
            vec_errs++;
         end
      end
      if ((chk & IRQ_LOW) != 0)
      begin
         assert (!tsc_irq)
         else
         begin
            $display("Fail at %0t: vector %0d tsc_irq still high", $time, base / VEC_WORDS);
            vec_errs++;
         end
      end
   endtask

   // The vector now sits in stage two, so its flush is visible
   task automatic close_vector(input int idx);
      logic [31:0] exp;
      exp = pat[idx*VEC_WORDS+7];
      if ((pat[idx*VEC_WORDS+6] & CHK_FLUSH) != 0)
      begin
         assert (exc_flush && exc_flush_tgt == exp[`EPU_PC_W-1:0])
         else
         begin
            $display("Fail at %0t: vector %0d flush %0b target %h, expected target %h",
                     $time, idx, exc_flush, exc_flush_tgt, exp[`EPU_PC_W-1:0]);
            vec_errs++;
         end
      end
      else
      begin
         assert (!exc_flush)
         else
         begin
            $display("Fail at %0t: vector %0d raised an unexpected flush", $time, idx);
            vec_errs++;
         end
      end
      if (vec_errs == 0)
      begin
         $display("vector %0d passed", idx);
         pass_cnt++;
      end
      else
      begin
         $display("vector %0d failed with %0d errors", idx, vec_errs);
         fail_cnt++;
      end
      vec_errs = 0;
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial
   begin
      int base;
      clk         = 1'b0;
      reset       = 1'b1;
      p_ce        = 1'b0;
      ex_valid    = 1'b0;
      ex_op       = EPU_OP_NONE;
      ex_operand1 = '0;
      ex_operand2 = '0;
      ex_imm      = '0;
      ex_pc       = '0;
      ex_npc      = '0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      vec_errs    = 0;
      timed_out   = 1'b0;
      n_vecs      = 0;
      void'($urandom(32'hd4248b69));
      $readmemh("sim/epu_patterns.txt", pat);
      while (n_vecs < MAX_VECS && pat[n_vecs*VEC_WORDS] != END_MARK)
         n_vecs++;

      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      if (n_vecs == 0 || n_vecs == MAX_VECS)
      begin
         $display("Pattern file sim/epu_patterns.txt is missing or has no end marker");
         fail_cnt++;
      end
      else
      begin
         for (int i = 0; i < n_vecs; i++)
         begin
            base = i * VEC_WORDS;
            if ((pat[base+6] & WAIT_IRQ) != 0)
               wait_irq();
            if (timed_out)
               break;
            stall_random();
            drive_vector(base, 1'b1);
            if (i > 0)
               close_vector(i - 1);
            verify_read(base);
         end
         // Trailing bubble lets the last vector reach stage two
         if (!timed_out)
         begin
            drive_vector((n_vecs - 1) * VEC_WORDS, 1'b0);
            close_vector(n_vecs - 1);
         end
      end

      $display("Vectors passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !timed_out)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* sim/epu_patterns.txt */
// op opnd1 imm opnd2 pc npc chk exp, all hex
// chk: 01 read equals exp, 02 flush to exp, 04 read at least exp, 08 wait tsc_irq, 10 irq low
1 00000000 0001 00000000 00000100 00000101 01 00000001 // PSR after reset
1 00000000 0002 00000000 00000101 00000102 01 4e435055
1 00000000 0020 00000000 00000102 00000103 01 00000000
1 00000600 0002 00000000 00000103 00000104 01 00000000 // bank 3 is unmapped
1 00000000 0008 00000000 00000104 00000105 01 00000000
2 00000000 0040 0000a000 00000105 00000106 00 00000000 // EVECT
2 00000000 0004 0000002a 00000106 00000107 00 00000000
2 00000000 0010 deadbeef 00000107 00000108 00 00000000
1 00000000 0040 00000000 00000108 00000109 01 0000a000
1 00000000 0004 00000000 00000109 0000010a 01 0000002a
1 00000000 0010 00000000 0000010a 0000010b 01 deadbeef
2 00000000 0008 00001234 0000010b 0000010c 00 00000000 // EPC for the ERET below
5 00000000 0000 00000000 0000010c 0000010d 02 0000048d
2 00000000 0040 fffff000 0000010d 0000010e 00 00000000 // killed
1 00000000 0001 00000000 0000010e 0000010f 01 0000002a
3 00000000 0000 00000000 00000200 00000201 02 00002840 // SYSCALL
2 00000000 0008 0badf00d 00000202 00000203 00 00000000 // killed
1 00000000 0008 00000000 00000203 00000204 01 00000804
1 00000000 0004 00000000 00000204 00000205 01 0000002a
1 00000000 0001 00000000 00000205 00000206 01 00000029
4 00000000 0000 00000000 00000300 00000301 02 00002880 // EINSN
2 00000000 0010 55555555 00000302 00000303 00 00000000 // killed
1 00000000 0010 00000000 00000303 00000304 01 00000c00
1 00000000 0008 00000000 00000304 00000305 01 00000c00
1 00000000 0040 00000000 00000305 00000306 01 0000a000
2 00000000 0001 000003c0 00000400 00000401 02 00000401 // PSR write
0 00000000 0000 00000000 00000402 00000403 00 00000000
1 00000000 0001 00000000 00000403 00000404 01 0000003c
2 00000e00 0002 30000010 00000500 00000501 00 00000000 // TCR EN, I, CNT 0x10
1 00000e00 0002 00000000 00000501 00000502 01 00000000 // write still in stage two
1 00000e00 0001 00000000 00000502 00000503 0c 00000010
2 00000e00 0002 00000000 00000503 00000504 00 00000000
1 00000e00 0002 00000000 00000504 00000505 01 30000010
1 00000e00 0002 00000000 00000505 00000506 11 00000000
ff

/* sources.f */
+incdir+include
verilog/epu_msr_pkg.sv
verilog/epu_pipe_pkg.sv
verilog/epu_decode.sv
verilog/epu_commit.sv
verilog/epu_msr_file.sv
verilog/epu_tsc.sv
verilog/epu_top.sv
sim/epu_props.sv
sim/epu_tb.sv

/* Makefile */
# Verilator build and run for the EPU testbench

VERILATOR ?= verilator
TOP       ?= epu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
